/* include/zxuno_consts.svh */
`ifndef ZXUNO_CONSTS_SVH
`define ZXUNO_CONSTS_SVH

// ----------------------------------------
// CPU I/O ports of the register bank
// ----------------------------------------
`define ZXUNO_ADDR_PORT 16'hFC3B
`define ZXUNO_DATA_PORT 16'hFD3B

// ----------------------------------------
// Option registers
// ----------------------------------------
`define NUM_OPTION_REGS 4

// Scandoubler control, device options, raster line, scratch
`define OPT_ADDR_0 8'h0B
`define OPT_ADDR_1 8'h0E
`define OPT_ADDR_2 8'h0C
`define OPT_ADDR_3 8'hFE

`define OPT_RESET_0 8'h00
`define OPT_RESET_1 8'h00
`define OPT_RESET_2 8'hFF
`define OPT_RESET_3 8'h00

// ----------------------------------------
// Core identification
// ----------------------------------------
`define COREID_ADDR 8'hFF
`define COREID_LEN 8
// "ZXUNO-RB", first character in the top byte
`define COREID_STRING 64'h5A58_554E_4F2D_5242

// Pulled-up data bus with nothing driving it
`define IDLE_BUS_BYTE 8'hFF

`endif

/* list.f */
+incdir+include
source/zxuno_pkg.sv
source/zxuno_port_decoder.sv
source/option_register.sv
source/coreid_reader.sv
source/read_data_mux.sv
source/zxuno_regbank.sv
testbench/tb_zxuno_regbank.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the register bank testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_zxuno_regbank
LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module "$TOP" -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/V$TOP > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Test failures found" "$LOG"; then
   echo "RESULT: FAIL"
   exit 1
fi

echo "RESULT: PASS"
exit 0

/* source/coreid_reader.sv */
`timescale 1ns/1ps

`include "zxuno_consts.svh"

module coreid_reader import zxuno_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  bus_op_t   op,
   input  reg_addr_t reg_addr,
   input  logic      data_rd,
   output byte_t     dout,
   output logic      oe_n
);

   // Index of the zero byte after the text
   localparam int LAST_IDX = `COREID_LEN;
   localparam logic [8*`COREID_LEN-1:0] ID_TEXT = `COREID_STRING;

   logic [3:0] idx;
   logic       id_addr;
   byte_t      cur_char;

   assign id_addr = (reg_addr == `COREID_ADDR);

   // ----------------------------------------
   // Character index
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         idx <= '0;
      end else if (op == OP_ADDR_WR) begin
         idx <= '0;
      end else if (op == OP_DATA_RD_DONE && id_addr) begin
         if (idx == LAST_IDX[3:0]) begin
            idx <= '0;
         end else begin
            idx <= idx + 4'd1;
         end
      end
   end

   // Characters go out first to last, then a terminator
   always_comb begin
      if (idx == LAST_IDX[3:0]) begin
         cur_char = 8'h00;
      end else begin
         cur_char = ID_TEXT[8*(LAST_IDX-1-int'(idx)) +: 8];
      end
   end

   assign oe_n = !(data_rd && id_addr);
   assign dout = oe_n ? `IDLE_BUS_BYTE : cur_char;

   assert property (@(posedge clk) disable iff (reset)
      idx <= LAST_IDX[3:0])
      else $error("core ID index out of range: %0d", idx);

endmodule

/* source/option_register.sv */
`timescale 1ns/1ps

`include "zxuno_consts.svh"

module option_register import zxuno_pkg::*; #(
   parameter reg_addr_t REG_ADDR    = 8'h00,
   parameter byte_t     RESET_VALUE = 8'h00
) (
   input  logic      clk,
   input  logic      reset,
   input  bus_op_t   op,
   input  reg_addr_t reg_addr,
   input  byte_t     wr_data,
   input  logic      data_rd,
   output byte_t     value,
   output byte_t     dout,
   output logic      oe_n
);

   logic  addr_match;
   logic  load;
   byte_t value_q;

   assign addr_match = (reg_addr == REG_ADDR);
   assign load       = (op == OP_DATA_WR) && addr_match;

   always_ff @(posedge clk) begin
      if (reset) begin
         value_q <= RESET_VALUE;
      end else if (load) begin
         value_q <= wr_data;
      end
   end

   assign value = value_q;

   // Drive the bus only while our address is read
   assign oe_n = !(data_rd && addr_match);
   assign dout = oe_n ? `IDLE_BUS_BYTE : value_q;

   // Value moves only on a write addressed to this slot
   assert property (@(posedge clk) disable iff (reset)
      !load |=> $stable(value))
      else $error("option register %h changed without a write", REG_ADDR);

endmodule

/* source/read_data_mux.sv */
`timescale 1ns/1ps

`include "zxuno_consts.svh"

module read_data_mux import zxuno_pkg::*; (
   input  logic      addr_rd,
   input  reg_addr_t reg_addr,
   input  byte_t     coreid_dout,
   input  logic      coreid_oe_n,
   input  byte_t     opt_dout [`NUM_OPTION_REGS],
   input  logic      opt_oe_n [`NUM_OPTION_REGS],
   output byte_t     dout,
   output logic      oe_n
);

   // All enables as active-high flags, address port on top
   logic [`NUM_OPTION_REGS+1:0] en_low;

   always_comb begin
      en_low[`NUM_OPTION_REGS+1] = addr_rd;
      en_low[`NUM_OPTION_REGS]   = !coreid_oe_n;
      for (int i = 0; i < `NUM_OPTION_REGS; i++) begin
         en_low[i] = !opt_oe_n[i];
      end
   end

   // ----------------------------------------
   // Priority select, later assignments win
   // ----------------------------------------
   always_comb begin
      dout = `IDLE_BUS_BYTE;
      oe_n = 1'b1;
      // Descending so the lowest slot index wins
      for (int i = `NUM_OPTION_REGS - 1; i >= 0; i--) begin
         if (!opt_oe_n[i]) begin
            dout = opt_dout[i];
            oe_n = 1'b0;
         end
      end
      if (!coreid_oe_n) begin
         dout = coreid_dout;
         oe_n = 1'b0;
      end
      if (addr_rd) begin
         dout = reg_addr;
         oe_n = 1'b0;
      end
   end

   // Sources decode disjoint ports and addresses
   always_comb begin
      assert ($onehot0(en_low))
         else $error("more than one source drives the CPU bus: %b", en_low);
   end

endmodule

/* source/zxuno_pkg.sv */
package zxuno_pkg;

   // One byte on the CPU data bus
   typedef logic [7:0] byte_t;

   // Address of a register behind the data port
   typedef logic [7:0] reg_addr_t;

   // One-cycle operation pulses from the port decoder
   typedef enum logic [1:0] {
      OP_NONE         = 2'd0,
      // New register address latched
      OP_ADDR_WR      = 2'd1,
      // Write to the selected register
      OP_DATA_WR      = 2'd2,
      // Read of the data port just released
      OP_DATA_RD_DONE = 2'd3
   } bus_op_t;

endpackage

/* source/zxuno_port_decoder.sv */
`timescale 1ns/1ps

`include "zxuno_consts.svh"

module zxuno_port_decoder import zxuno_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  logic [15:0] a,
   input  logic        iorq_n,
   input  logic        rd_n,
   input  logic        wr_n,
   input  byte_t       din,
   output bus_op_t     op,
   output reg_addr_t   reg_addr,
   output byte_t       wr_data,
   output logic        addr_rd,
   output logic        data_rd
);

   logic addr_hit;
   logic data_hit;
   logic rd_cycle;
   logic wr_cycle;

   // Accesses active in this cycle
   logic addr_wr_now;
   logic data_wr_now;
   logic data_rd_now;

   // Same accesses one cycle back
   logic addr_wr_q;
   logic data_wr_q;
   logic data_rd_q;

   logic addr_wr_first;
   logic data_wr_first;
   logic data_rd_release;

   reg_addr_t reg_addr_q;
   byte_t     wr_data_q;

   // ----------------------------------------
   // Port decode
   // ----------------------------------------
   assign addr_hit = (a == `ZXUNO_ADDR_PORT);
   assign data_hit = (a == `ZXUNO_DATA_PORT);
   assign rd_cycle = !iorq_n && !rd_n;
   assign wr_cycle = !iorq_n && !wr_n;

   assign addr_wr_now = addr_hit && wr_cycle;
   assign data_wr_now = data_hit && wr_cycle;
   assign data_rd_now = data_hit && rd_cycle;

   // Reads are seen combinationally by the data sources
   assign addr_rd = addr_hit && rd_cycle;
   assign data_rd = data_rd_now;

   // First cycle of a write, release cycle of a data read
   assign addr_wr_first   = addr_wr_now && !addr_wr_q;
   assign data_wr_first   = data_wr_now && !data_wr_q;
   assign data_rd_release = data_rd_q && !data_rd_now;

   always_ff @(posedge clk) begin
      if (reset) begin
         addr_wr_q  <= 1'b0;
         data_wr_q  <= 1'b0;
         data_rd_q  <= 1'b0;
         reg_addr_q <= '0;
      end else begin
         addr_wr_q <= addr_wr_now;
         data_wr_q <= data_wr_now;
         data_rd_q <= data_rd_now;
         if (addr_wr_first) begin
            reg_addr_q <= din;
         end
      end
   end

   // Write byte held for the rest of the access
   always_ff @(posedge clk) begin
      if (addr_wr_first || data_wr_first) begin
         wr_data_q <= din;
      end
   end

   assign wr_data  = data_wr_first ? din : wr_data_q;
   assign reg_addr = reg_addr_q;

   always_comb begin
      op = OP_NONE;
      if (addr_wr_first) begin
         op = OP_ADDR_WR;
      end else if (data_wr_first) begin
         op = OP_DATA_WR;
      end else if (data_rd_release) begin
         op = OP_DATA_RD_DONE;
      end
   end

   // Held strobes never produce a second write
   assert property (@(posedge clk) disable iff (reset)
      (op inside {OP_ADDR_WR, OP_DATA_WR}) |=> !(op inside {OP_ADDR_WR, OP_DATA_WR}))
      else $error("write pulse repeated on consecutive cycles");

endmodule

/* source/zxuno_regbank.sv */
`timescale 1ns/1ps

`include "zxuno_consts.svh"

module zxuno_regbank import zxuno_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  logic [15:0] a,
   input  byte_t       din,
   input  logic        iorq_n,
   input  logic        rd_n,
   input  logic        wr_n,
   output byte_t       dout,
   output logic        oe_n,
   output byte_t       scndbl_ctrl,
   output byte_t       dev_options,
   output byte_t       raster_line,
   output byte_t       scratch
);

   // Address and reset value of each option slot
   localparam reg_addr_t OPT_ADDRS [`NUM_OPTION_REGS] =
      '{`OPT_ADDR_0, `OPT_ADDR_1, `OPT_ADDR_2, `OPT_ADDR_3};
   localparam byte_t OPT_RESETS [`NUM_OPTION_REGS] =
      '{`OPT_RESET_0, `OPT_RESET_1, `OPT_RESET_2, `OPT_RESET_3};

   bus_op_t   op;
   reg_addr_t reg_addr;
   byte_t     wr_data;
   logic      addr_rd;
   logic      data_rd;

   byte_t coreid_dout;
   logic  coreid_oe_n;

   byte_t opt_value [`NUM_OPTION_REGS];
   byte_t opt_dout  [`NUM_OPTION_REGS];
   logic  opt_oe_n  [`NUM_OPTION_REGS];

   // ----------------------------------------
   // CPU port decode
   // ----------------------------------------
   zxuno_port_decoder u_decoder (
      .clk      (clk),
      .reset    (reset),
      .a        (a),
      .iorq_n   (iorq_n),
      .rd_n     (rd_n),
      .wr_n     (wr_n),
      .din      (din),
      .op       (op),
      .reg_addr (reg_addr),
      .wr_data  (wr_data),
      .addr_rd  (addr_rd),
      .data_rd  (data_rd)
   );

   // ----------------------------------------
   // Option registers
   // ----------------------------------------
   for (genvar i = 0; i < `NUM_OPTION_REGS; i++) begin : g_opt
      option_register #(
         .REG_ADDR    (OPT_ADDRS[i]),
         .RESET_VALUE (OPT_RESETS[i])
      ) u_opt (
         .clk      (clk),
         .reset    (reset),
         .op       (op),
         .reg_addr (reg_addr),
         .wr_data  (wr_data),
         .data_rd  (data_rd),
         .value    (opt_value[i]),
         .dout     (opt_dout[i]),
         .oe_n     (opt_oe_n[i])
      );
   end

   assign scndbl_ctrl = opt_value[0];
   assign dev_options = opt_value[1];
   assign raster_line = opt_value[2];
   assign scratch     = opt_value[3];

   coreid_reader u_coreid (
      .clk      (clk),
      .reset    (reset),
      .op       (op),
      .reg_addr (reg_addr),
      .data_rd  (data_rd),
      .dout     (coreid_dout),
      .oe_n     (coreid_oe_n)
   );

   // Byte returned to the CPU
   read_data_mux u_mux (
      .addr_rd     (addr_rd),
      .reg_addr    (reg_addr),
      .coreid_dout (coreid_dout),
      .coreid_oe_n (coreid_oe_n),
      .opt_dout    (opt_dout),
      .opt_oe_n    (opt_oe_n),
      .dout        (dout),
      .oe_n        (oe_n)
   );

endmodule

/* testbench/tb_zxuno_regbank.sv */
`timescale 1ns/1ps

`include "zxuno_consts.svh"

module tb_zxuno_regbank import zxuno_pkg::*; ();

   localparam int RESET_CYCLES = 5;
   // Five-cycle bus accesses per test
   localparam int ACC_RESET   = 9;
   localparam int ACC_ADDR    = 10;
   localparam int ACC_RANDOM  = 160;
   localparam int ACC_UNKNOWN = 11;
   localparam int ACC_COREID  = 15;
   localparam int ACC_DIN     = 5;
   localparam int CYCLE_LIMIT = 2 * 5 * (ACC_RESET + ACC_ADDR + ACC_RANDOM + ACC_UNKNOWN
      + ACC_COREID + ACC_DIN) + RESET_CYCLES;

   localparam byte_t OPT_ADDRS [`NUM_OPTION_REGS] =
      '{`OPT_ADDR_0, `OPT_ADDR_1, `OPT_ADDR_2, `OPT_ADDR_3};
   localparam byte_t OPT_RESETS [`NUM_OPTION_REGS] =
      '{`OPT_RESET_0, `OPT_RESET_1, `OPT_RESET_2, `OPT_RESET_3};
   localparam logic [63:0] ID_TEXT = "ZXUNO-RB";

   logic        clk = 1'b0;
   logic        reset;
   logic [15:0] a;
   byte_t       din;
   logic        iorq_n;
   logic        rd_n;
   logic        wr_n;
   byte_t       dout;
   logic        oe_n;
   byte_t       scndbl_ctrl;
   byte_t       dev_options;
   byte_t       raster_line;
   byte_t       scratch;

   // Reference model state
   byte_t       model_regs [`NUM_OPTION_REGS];
   reg_addr_t   model_addr;
   int          model_idx;
   logic [31:0] rng_state = 32'hea85;

   // Pending comparisons filled by the access tasks
   logic [8:0]  exp_q [$];
   logic [8:0]  act_q [$];
   string       what_q [$];
   event        check_ev;

   int          posted_count = 0;
   int          check_count = 0;
   int          error_count = 0;
   int          cycle_count = 0;
   byte_t       prev_scratch = '0;
   logic [7:0]  scratch_changes = '0;

   always #10 clk = ~clk;

   zxuno_regbank DUT (
      .clk         (clk),
      .reset       (reset),
      .a           (a),
      .din         (din),
      .iorq_n      (iorq_n),
      .rd_n        (rd_n),
      .wr_n        (wr_n),
      .dout        (dout),
      .oe_n        (oe_n),
      .scndbl_ctrl (scndbl_ctrl),
      .dev_options (dev_options),
      .raster_line (raster_line),
      .scratch     (scratch)
   );

   // ----------------------------------------
   // Reference model
   // ----------------------------------------
   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = xorshift(rng_state);
      return rng_state;
   endfunction

   function automatic void model_write(input logic [15:0] port, input byte_t data);
      if (port == `ZXUNO_ADDR_PORT) begin
         model_addr = data;
         model_idx  = 0;
      end else if (port == `ZXUNO_DATA_PORT) begin
         for (int i = 0; i < `NUM_OPTION_REGS; i++) begin
            if (model_addr == OPT_ADDRS[i]) begin
               model_regs[i] = data;
            end
         end
      end
   endfunction

   // Expected {oe_n, dout} for a read of the given port
   function automatic logic [8:0] expected_read(input logic [15:0] port);
      logic [8:0] res;
      res = {1'b1, 8'hFF};
      if (port == `ZXUNO_ADDR_PORT) begin
         res = {1'b0, model_addr};
      end else if (port == `ZXUNO_DATA_PORT && model_addr == `COREID_ADDR) begin
         if (model_idx == `COREID_LEN) begin
            res = {1'b0, 8'h00};
         end else begin
            res = {1'b0, ID_TEXT[8*(`COREID_LEN-1-model_idx) +: 8]};
         end
      end else if (port == `ZXUNO_DATA_PORT) begin
         for (int i = 0; i < `NUM_OPTION_REGS; i++) begin
            if (model_addr == OPT_ADDRS[i]) begin
               res = {1'b0, model_regs[i]};
            end
         end
      end
      return res;
   endfunction

   function automatic byte_t output_port(input int i);
      case (i)
         0: return scndbl_ctrl;
         1: return dev_options;
         2: return raster_line;
         default: return scratch;
      endcase
   endfunction

   // ----------------------------------------
   // Bus access tasks
   // ----------------------------------------
   task automatic post_check(input string what, input logic [8:0] exp, input logic [8:0] act);
      exp_q.push_back(exp);
      act_q.push_back(act);
      what_q.push_back(what);
      posted_count++;
      -> check_ev;
   endtask

   // Write whose din moves to a second value after the first cycle
   task automatic write_access(input logic [15:0] port, input byte_t first, input byte_t later);
      @(negedge clk);
      a      = port;
      din    = first;
      iorq_n = 1'b0;
      wr_n   = 1'b0;
      model_write(port, first);
      @(negedge clk);
      din = later;
      repeat (2) @(negedge clk);
      iorq_n = 1'b1;
      wr_n   = 1'b1;
      @(negedge clk);
   endtask

   task automatic bus_write(input logic [15:0] port, input byte_t data);
      write_access(port, data, data);
   endtask

   task automatic bus_read(input logic [15:0] port, input string what);
      logic [8:0] exp;
      logic [8:0] act;
      exp = expected_read(port);
      @(negedge clk);
      a      = port;
      iorq_n = 1'b0;
      rd_n   = 1'b0;
      @(posedge clk);
      @(posedge clk);
      act = {oe_n, dout};
      post_check(what, exp, act);
      repeat (2) @(negedge clk);
      iorq_n = 1'b1;
      rd_n   = 1'b1;
      // Core ID advances at the release edge
      if (port == `ZXUNO_DATA_PORT && model_addr == `COREID_ADDR) begin
         model_idx = (model_idx == `COREID_LEN) ? 0 : model_idx + 1;
      end
      @(negedge clk);
   endtask

   task automatic check_outputs(input string what);
      for (int i = 0; i < `NUM_OPTION_REGS; i++) begin
         post_check($sformatf("%s, output port %0d", what, i), {1'b0, model_regs[i]},
            {1'b0, output_port(i)});
      end
   endtask

   // ----------------------------------------
   // Compare process and run limit
   // ----------------------------------------
   always @(check_ev) begin
      logic [8:0] exp;
      logic [8:0] act;
      string      what;
      while (act_q.size() > 0) begin
         exp  = exp_q.pop_front();
         act  = act_q.pop_front();
         what = what_q.pop_front();
         assert (act === exp)
            else begin
               error_count++;
               $display("CHECK FAILED at %0t ns: %s, expected oe_n=%b dout=%h, got oe_n=%b dout=%h",
                  $time, what, exp[8], exp[7:0], act[8], act[7:0]);
            end
         check_count++;
      end
   end

   always @(posedge clk) begin
      if (scratch !== prev_scratch) begin
         scratch_changes <= scratch_changes + 8'd1;
      end
      prev_scratch <= scratch;
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Test failures found");
         $finish;
      end
   end

   // ----------------------------------------
   // Tests
   // ----------------------------------------
   int tests_run = 0;
   int tests_failed = 0;
   int errors_before = 0;

   task automatic finish_test(input string name);
      int errs;
      // Let the compare process drain every posted check
      wait (check_count == posted_count);
      errs = error_count - errors_before;
      tests_run++;
      if (errs == 0) begin
         $display("Test %0d (%s): ok", tests_run, name);
      end else begin
         tests_failed++;
         $display("Test %0d (%s): FAILED with %0d errors", tests_run, name, errs);
      end
      errors_before = error_count;
   endtask

   initial begin
      logic [31:0] r;
      int          slot;
      byte_t       v;
      logic [7:0]  changes_before;
      reset  = 1'b1;
      a      = '0;
      din    = '0;
      iorq_n = 1'b1;
      rd_n   = 1'b1;
      wr_n   = 1'b1;
      model_addr = '0;
      model_idx  = 0;
      for (int i = 0; i < `NUM_OPTION_REGS; i++) begin
         model_regs[i] = OPT_RESETS[i];
      end
      repeat (RESET_CYCLES) @(negedge clk);
      reset = 1'b0;

      bus_read(`ZXUNO_ADDR_PORT, "address after reset");
      check_outputs("after reset");
      for (int i = 0; i < `NUM_OPTION_REGS; i++) begin
         bus_write(`ZXUNO_ADDR_PORT, OPT_ADDRS[i]);
         bus_read(`ZXUNO_DATA_PORT, $sformatf("reset value of slot %0d", i));
      end
      finish_test("reset state");

      for (int n = 0; n < 3; n++) begin
         r = next_rand();
         bus_write(`ZXUNO_ADDR_PORT, r[7:0]);
         repeat (4) @(negedge clk);
         bus_read(`ZXUNO_ADDR_PORT, "address port read-back");
      end
      finish_test("address port");

      for (int n = 0; n < 40; n++) begin
         r    = next_rand();
         slot = int'(r[1:0]);
         v    = r[15:8];
         bus_write(`ZXUNO_ADDR_PORT, OPT_ADDRS[slot]);
         bus_write(`ZXUNO_DATA_PORT, v);
         slot = int'(r[25:24]);
         bus_write(`ZXUNO_ADDR_PORT, OPT_ADDRS[slot]);
         bus_read(`ZXUNO_DATA_PORT, $sformatf("random read-back of slot %0d", slot));
         check_outputs("random writes");
      end
      finish_test("random option writes");

      bus_write(`ZXUNO_ADDR_PORT, 8'h42);
      bus_read(`ZXUNO_DATA_PORT, "unknown register address");
      bus_write(`ZXUNO_DATA_PORT, 8'h99);
      check_outputs("write to unknown address");
      for (int i = 0; i < `NUM_OPTION_REGS; i++) begin
         bus_write(`ZXUNO_ADDR_PORT, OPT_ADDRS[i]);
         bus_read(`ZXUNO_DATA_PORT, $sformatf("slot %0d after unknown write", i));
      end
      finish_test("unknown address");

      bus_write(`ZXUNO_ADDR_PORT, `COREID_ADDR);
      for (int n = 0; n < 11; n++) begin
         bus_read(`ZXUNO_DATA_PORT, $sformatf("core ID character %0d", n));
      end
      bus_write(`ZXUNO_ADDR_PORT, `COREID_ADDR);
      for (int n = 0; n < 2; n++) begin
         bus_read(`ZXUNO_DATA_PORT, $sformatf("core ID after restart, character %0d", n));
      end
      finish_test("core ID");

      bus_write(`ZXUNO_ADDR_PORT, `OPT_ADDR_3);
      bus_write(`ZXUNO_DATA_PORT, 8'h00);
      changes_before = scratch_changes;
      write_access(`ZXUNO_DATA_PORT, 8'h5A, 8'hA5);
      bus_read(`ZXUNO_DATA_PORT, "first-cycle write data");
      check_outputs("changing din");
      post_check("scratch change count", {1'b0, 8'd1},
         {1'b0, scratch_changes - changes_before});
      finish_test("changing din");

      $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
         tests_run, tests_failed, check_count, error_count);
      if (error_count == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule
